// ==== activity_stretch.sv ====
module activity_stretch (
	input  logic                                      clk_250mhz,
	input  logic                                      rst_n,
	input  logic [trigger_crossbar_pkg::NUM_TRIG-1:0] trig,
	output logic [trigger_crossbar_pkg::NUM_TRIG-1:0] led
);

	// One hold timer per trigger bit
	trigger_crossbar_pkg::led_cnt_t hold_cnt [trigger_crossbar_pkg::NUM_TRIG];

	always_ff @(posedge clk_250mhz) begin
		if (!rst_n) begin
			for (int i = 0; i < trigger_crossbar_pkg::NUM_TRIG; i++) begin
				hold_cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < trigger_crossbar_pkg::NUM_TRIG; i++) begin
				// Any high sample restarts the hold window
				if (trig[i]) begin
					hold_cnt[i] <= trigger_crossbar_pkg::led_cnt_t'(
						trigger_crossbar_pkg::LED_HOLD_CYCLES);
				end else if (hold_cnt[i] != '0) begin
					hold_cnt[i] <= hold_cnt[i] - 1'b1;
				end
			end
		end
	end

	// LED lit while its timer runs
	always_comb begin
		for (int i = 0; i < trigger_crossbar_pkg::NUM_TRIG; i++) begin
			led[i] = (hold_cnt[i] != '0);
		end
	end

endmodule

// ==== crossbar_matrix.sv ====
module crossbar_matrix (
	input  logic                                                           clk_250mhz,
	input  logic                                                           rst_n,
	input  logic [trigger_crossbar_pkg::NUM_TRIG-1:0]                      trig_in,
	input  trigger_crossbar_pkg::muxsel_t [trigger_crossbar_pkg::NUM_TRIG-1:0] muxsel,
	output logic [trigger_crossbar_pkg::NUM_TRIG-1:0]                      trig_fixed,
	output logic [trigger_crossbar_pkg::NUM_TRIG-1:0]                      trig_out
);

	//////////////////////////////////////////////////
	// Stage 1, capture inputs and undo P/N swaps

	always_ff @(posedge clk_250mhz) begin
		if (!rst_n) begin
			trig_fixed <= '0;
		end else begin
			trig_fixed <= trig_in ^ trigger_crossbar_pkg::TRIG_SWAP_MASK;
		end
	end

	//////////////////////////////////////////////////
	// Stage 2, one registered mux per output

	always_ff @(posedge clk_250mhz) begin
		if (!rst_n) begin
			trig_out <= '0;
		end else begin
			for (int i = 0; i < trigger_crossbar_pkg::NUM_TRIG; i++) begin
				// In-range select routes a corrected input
				if (muxsel[i] < trigger_crossbar_pkg::NUM_TRIG) begin
					trig_out[i] <= trig_fixed[muxsel[i]];
				end else begin
					// Off or unused codes
					trig_out[i] <= 1'b0;
				end
			end
		end
	end

	// Selects come from the register block, an unused code must silence the output
	for (genvar i = 0; i < trigger_crossbar_pkg::NUM_TRIG; i++) begin : g_off_chk
		a_off_is_low: assert property (
			@(posedge clk_250mhz) disable iff (!rst_n)
			(muxsel[i] >= trigger_crossbar_pkg::NUM_TRIG) |=> !trig_out[i]
		);
	end

endmodule

// ==== mgmt_regs.sv ====
module mgmt_regs (
	input  logic                                                           clk_250mhz,
	input  logic                                                           rst_n,
	input  logic                                                           reg_wr,
	input  logic                                                           reg_rd,
	input  logic [trigger_crossbar_pkg::REG_ADDR_W-1:0]                    reg_addr,
	input  logic [trigger_crossbar_pkg::REG_DATA_W-1:0]                    reg_wdata,
	output logic [trigger_crossbar_pkg::REG_DATA_W-1:0]                    reg_rdata,
	output trigger_crossbar_pkg::muxsel_t [trigger_crossbar_pkg::NUM_TRIG-1:0] muxsel,
	input  logic [trigger_crossbar_pkg::NUM_TRIG-1:0]                      in_led,
	input  logic [trigger_crossbar_pkg::NUM_TRIG-1:0]                      out_led,
	relay_if.mgmt                                                          relay
);

	// Offset into the select block and whether it hits a real output
	logic [trigger_crossbar_pkg::REG_ADDR_W-1:0] sel_idx;
	logic                                        sel_hit;
	logic                                        cmd_wr;

	assign sel_idx = reg_addr - trigger_crossbar_pkg::REG_MUXSEL_BASE;
	assign sel_hit = (sel_idx < trigger_crossbar_pkg::NUM_TRIG);
	assign cmd_wr  = reg_wr && (reg_addr == trigger_crossbar_pkg::REG_RELAY_CMD);

	//////////////////////////////////////////////////
	// Writes, selects and relay commands

	logic                              en_q;
	logic                              dir_q;
	trigger_crossbar_pkg::relay_chan_t chan_q;

	always_ff @(posedge clk_250mhz) begin
		if (!rst_n) begin
			for (int i = 0; i < trigger_crossbar_pkg::NUM_TRIG; i++) begin
				muxsel[i] <= trigger_crossbar_pkg::MUXSEL_OFF;
			end
			en_q   <= 1'b0;
			dir_q  <= 1'b0;
			chan_q <= '0;
		end else begin
			if (reg_wr && sel_hit) begin
				muxsel[sel_idx] <= reg_wdata[$bits(trigger_crossbar_pkg::muxsel_t)-1:0];
			end
			// Back-to-back command writes collapse into one strobe
			en_q <= cmd_wr && !en_q;
			if (cmd_wr && !en_q) begin
				dir_q  <= reg_wdata[trigger_crossbar_pkg::RELAY_CMD_DIR_BIT];
				chan_q <= reg_wdata[$bits(trigger_crossbar_pkg::relay_chan_t)-1:0];
			end
		end
	end

	assign relay.en      = en_q;
	assign relay.dir     = dir_q;
	assign relay.channel = chan_q;

	//////////////////////////////////////////////////
	// Status and readback

	logic                                        done_flag;
	logic                                        stat_rd;
	logic [trigger_crossbar_pkg::REG_DATA_W-1:0] rd_mux;

	assign stat_rd = reg_rd && (reg_addr == trigger_crossbar_pkg::REG_RELAY_STAT);

	always_comb begin
		rd_mux = '0;
		if (sel_hit) begin
			rd_mux[$bits(trigger_crossbar_pkg::muxsel_t)-1:0] = muxsel[sel_idx];
		end else if (reg_addr == trigger_crossbar_pkg::REG_IN_LED) begin
			rd_mux[trigger_crossbar_pkg::NUM_TRIG-1:0] = in_led;
		end else if (reg_addr == trigger_crossbar_pkg::REG_OUT_LED) begin
			rd_mux[trigger_crossbar_pkg::NUM_TRIG-1:0] = out_led;
		end else if (reg_addr == trigger_crossbar_pkg::REG_RELAY_STAT) begin
			rd_mux[trigger_crossbar_pkg::RELAY_STAT_BUSY_BIT] = relay.busy;
			rd_mux[trigger_crossbar_pkg::RELAY_STAT_DONE_BIT] = done_flag;
		end
	end

	always_ff @(posedge clk_250mhz) begin
		if (!rst_n) begin
			done_flag <= 1'b0;
			reg_rdata <= '0;
		end else begin
			// A new completion wins over a clearing read
			if (relay.done) begin
				done_flag <= 1'b1;
			end else if (stat_rd) begin
				done_flag <= 1'b0;
			end
			// Read data holds until the next read
			if (reg_rd) begin
				reg_rdata <= rd_mux;
			end
		end
	end

	a_en_single: assert property (
		@(posedge clk_250mhz) disable iff (!rst_n) en_q |=> !en_q);

endmodule

// ==== relay_controller.sv ====
module relay_controller (
	input  logic                                       clk_250mhz,
	input  logic                                       rst_n,
	relay_if.relay                                     relay,
	output logic [trigger_crossbar_pkg::NUM_RELAY-1:0] relay_a,
	output logic [trigger_crossbar_pkg::NUM_RELAY-1:0] relay_b
);

	//////////////////////////////////////////////////
	// Pulse sequencer

	logic                              busy_q;
	logic                              done_q;
	logic                              dir_q;
	trigger_crossbar_pkg::relay_chan_t chan_q;
	trigger_crossbar_pkg::relay_cnt_t  pulse_cnt;

	always_ff @(posedge clk_250mhz) begin
		if (!rst_n) begin
			busy_q    <= 1'b0;
			done_q    <= 1'b0;
			dir_q     <= 1'b0;
			chan_q    <= '0;
			pulse_cnt <= '0;
		end else begin
			done_q <= 1'b0;
			if (!busy_q) begin
				// Idle, accept a new command
				if (relay.en) begin
					busy_q    <= 1'b1;
					dir_q     <= relay.dir;
					chan_q    <= relay.channel;
					pulse_cnt <= trigger_crossbar_pkg::relay_cnt_t'(
						trigger_crossbar_pkg::RELAY_PULSE_CYCLES - 1);
				end
			end else if (pulse_cnt == '0) begin
				// Last coil cycle, release and flag completion
				busy_q <= 1'b0;
				done_q <= 1'b1;
			end else begin
				pulse_cnt <= pulse_cnt - 1'b1;
			end
		end
	end

	assign relay.busy = busy_q;
	assign relay.done = done_q;

	//////////////////////////////////////////////////
	// H-bridge coil drive

	// dir 1 energizes the A side, dir 0 the B side
	always_comb begin
		relay_a = '0;
		relay_b = '0;
		if (busy_q) begin
			if (dir_q) begin
				relay_a[chan_q] = 1'b1;
			end else begin
				relay_b[chan_q] = 1'b1;
			end
		end
	end

	// Both halves of a bridge on would short the supply
	a_no_shoot_through: assert property (
		@(posedge clk_250mhz) disable iff (!rst_n) (relay_a & relay_b) == '0);

	// Only one coil energized across all relays
	a_one_coil: assert property (
		@(posedge clk_250mhz) disable iff (!rst_n) $onehot0({relay_a, relay_b}));

endmodule

// ==== relay_if.sv ====
interface relay_if;

	// Command side, en is a single-cycle strobe
	logic                              en;
	logic                              dir;
	trigger_crossbar_pkg::relay_chan_t channel;

	// Status side
	logic busy;
	// One cycle after the coil drops
	logic done;

	modport mgmt (
		output en, dir, channel,
		input  busy, done
	);

	modport relay (
		input  en, dir, channel,
		output busy, done
	);

endinterface

// ==== tb_clock_gen.sv ====
module tb_clock_gen #(
	parameter int PERIOD_NS    = 4,
	parameter int RESET_CYCLES = 4
) (
	output logic clk_250mhz,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	// Free-running clock
	initial begin
		clk_250mhz = 1'b0;
		forever #(PERIOD_NS / 2.0) clk_250mhz = ~clk_250mhz;
	end

	// Reset held low, released on a rising edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_250mhz);
		rst_n <= 1'b1;
	end

endmodule

// ==== tb_trigger_crossbar.sv ====
module tb_trigger_crossbar;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NT = trigger_crossbar_pkg::NUM_TRIG;
	localparam int SEL_W = NT * $bits(trigger_crossbar_pkg::muxsel_t);
	localparam logic [NT-1:0] MASK = trigger_crossbar_pkg::TRIG_SWAP_MASK;
	localparam int CLK_PERIOD_NS = 4;
	localparam int NUM_ROWS = 9;
	// Watchdog budget in clocks
	localparam int ROW_BUDGET = 120;
	localparam int RELAY_BUDGET = 200;
	localparam int LED_BUDGET = 250;
	localparam int WATCHDOG_NS =
		(NUM_ROWS * ROW_BUDGET + 2 * RELAY_BUDGET + LED_BUDGET + 50) * CLK_PERIOD_NS;
	localparam int PULSE_LIMIT = trigger_crossbar_pkg::RELAY_PULSE_CYCLES + 8;
	// Corrected pattern for the LED check
	localparam logic [NT-1:0] LED_PATTERN = 12'h909;

	typedef logic [trigger_crossbar_pkg::REG_ADDR_W-1:0] addr_t;
	typedef logic [trigger_crossbar_pkg::REG_DATA_W-1:0] data_t;

	logic        clk_250mhz;
	logic        rst_n;
	logic [NT-1:0] trig_in;
	logic [NT-1:0] trig_out;
	logic [3:0]  relay_a;
	logic [3:0]  relay_b;
	logic        reg_wr;
	logic        reg_rd;
	addr_t       reg_addr;
	data_t       reg_wdata;
	data_t       reg_rdata;

	// Table rows, select of output i in bits 4i+3:4i
	logic [SEL_W-1:0] tbl_sel [NUM_ROWS];
	logic [NT-1:0]    tbl_raw [NUM_ROWS];
	logic [NT-1:0]    tbl_exp [NUM_ROWS];
	logic [31:0]      lfsr_state;
	int               error_count;
	int               check_count;

	tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(4)) clock_gen (
		.clk_250mhz (clk_250mhz),
		.rst_n      (rst_n)
	);

	trigger_crossbar_top trigger_crossbar_top_i (
		.clk_250mhz (clk_250mhz),
		.rst_n      (rst_n),
		.trig_in    (trig_in),
		.trig_out   (trig_out),
		.relay_a    (relay_a),
		.relay_b    (relay_b),
		.reg_wr     (reg_wr),
		.reg_rd     (reg_rd),
		.reg_addr   (reg_addr),
		.reg_wdata  (reg_wdata),
		.reg_rdata  (reg_rdata)
	);

	//////////////////////////////////////////////////
	// Reference model and random source

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [SEL_W-1:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[SEL_W-2:0], lfsr_state[0]};
		end
	endtask

	// Undo swaps, then pick per output or drive low
	function automatic logic [NT-1:0] route(input logic [SEL_W-1:0] sels,
			input logic [NT-1:0] raw);
		logic [NT-1:0] fixed;
		logic [NT-1:0] res;
		logic [3:0]    s;
		fixed = raw ^ MASK;
		res = '0;
		for (int i = 0; i < NT; i++) begin
			s = sels[4*i +: 4];
			if (s < NT) begin
				res[i] = fixed[s];
			end
		end
		return res;
	endfunction

	task automatic check_value(input data_t got, input data_t exp, input string what);
		check_count++;
		assert (got === exp) else begin
			$display("ERROR %0t ns: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
			error_count++;
		end
	endtask

	//////////////////////////////////////////////////
	// Register port access

	task automatic write_reg(input addr_t addr, input data_t data);
		@(posedge clk_250mhz);
		reg_wr    <= 1'b1;
		reg_addr  <= addr;
		reg_wdata <= data;
		@(posedge clk_250mhz);
		reg_wr    <= 1'b0;
	endtask

	// Data sampled mid-cycle after the capturing edge
	task automatic read_reg(input addr_t addr, output data_t data);
		@(posedge clk_250mhz);
		reg_rd   <= 1'b1;
		reg_addr <= addr;
		@(posedge clk_250mhz);
		reg_rd   <= 1'b0;
		@(negedge clk_250mhz);
		data = reg_rdata;
	endtask

	task automatic write_selects(input logic [SEL_W-1:0] sels);
		for (int i = 0; i < NT; i++) begin
			write_reg(addr_t'(trigger_crossbar_pkg::REG_MUXSEL_BASE + i), data_t'(sels[4*i +: 4]));
		end
	endtask

	task automatic fill_table();
		logic [SEL_W-1:0] bits;
		// Identity, shared input, all off, reversed, mixed
		tbl_sel[0] = 48'hBA9876543210; tbl_raw[0] = 12'h000; tbl_exp[0] = 12'h065;
		tbl_sel[1] = 48'hBA9876543210; tbl_raw[1] = 12'hFFF; tbl_exp[1] = 12'hF9A;
		tbl_sel[2] = 48'h333333333333; tbl_raw[2] = 12'h008; tbl_exp[2] = 12'hFFF;
		tbl_sel[3] = 48'hFEDCFEDCFEDC; tbl_raw[3] = 12'hFFF; tbl_exp[3] = 12'h000;
		tbl_sel[4] = 48'h0123456789AB; tbl_raw[4] = 12'h801; tbl_exp[4] = 12'h261;
		tbl_sel[5] = 48'h16DB22FC5500; tbl_raw[5] = 12'h000; tbl_exp[5] = 12'h4CF;
		for (int r = 6; r < NUM_ROWS; r++) begin
			take_bits(SEL_W, bits);
			tbl_sel[r] = bits;
			take_bits(NT, bits);
			tbl_raw[r] = bits[NT-1:0];
			tbl_exp[r] = route(tbl_sel[r], tbl_raw[r]);
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequences

	task automatic run_row(input int r);
		data_t rd;
		write_selects(tbl_sel[r]);
		for (int i = 0; i < NT; i++) begin
			read_reg(addr_t'(trigger_crossbar_pkg::REG_MUXSEL_BASE + i), rd);
			check_value(rd, data_t'(tbl_sel[r][4*i +: 4]), $sformatf("row %0d select %0d", r, i));
		end
		@(posedge clk_250mhz);
		trig_in <= tbl_raw[r];
		// Two register stages to the output
		repeat (2) @(posedge clk_250mhz);
		@(negedge clk_250mhz);
		check_value(data_t'(trig_out), data_t'(tbl_exp[r]), $sformatf("row %0d trig_out", r));
	endtask

	task automatic led_test();
		data_t rd;
		write_selects(tbl_sel[5]);
		@(posedge clk_250mhz);
		trig_in <= MASK;
		repeat (trigger_crossbar_pkg::LED_HOLD_CYCLES + 6) @(posedge clk_250mhz);
		read_reg(trigger_crossbar_pkg::REG_IN_LED, rd);
		check_value(rd, '0, "idle input LEDs");
		read_reg(trigger_crossbar_pkg::REG_OUT_LED, rd);
		check_value(rd, '0, "idle output LEDs");
		// Single-cycle trigger burst
		@(posedge clk_250mhz);
		trig_in <= LED_PATTERN ^ MASK;
		@(posedge clk_250mhz);
		trig_in <= MASK;
		repeat (3) @(posedge clk_250mhz);
		read_reg(trigger_crossbar_pkg::REG_IN_LED, rd);
		check_value(rd, data_t'(LED_PATTERN), "stretched input LEDs");
		read_reg(trigger_crossbar_pkg::REG_OUT_LED, rd);
		check_value(rd, data_t'(route(tbl_sel[5], LED_PATTERN ^ MASK)), "stretched output LEDs");
		repeat (trigger_crossbar_pkg::LED_HOLD_CYCLES + 6) @(posedge clk_250mhz);
		read_reg(trigger_crossbar_pkg::REG_IN_LED, rd);
		check_value(rd, '0, "input LEDs after hold");
		read_reg(trigger_crossbar_pkg::REG_OUT_LED, rd);
		check_value(rd, '0, "output LEDs after hold");
	endtask

	task automatic relay_test(input trigger_crossbar_pkg::relay_chan_t chan, input logic dir);
		logic [3:0] coil;
		logic [3:0] other;
		data_t      rd;
		int         len;
		int         guard;
		write_reg(trigger_crossbar_pkg::REG_RELAY_CMD, {13'b0, dir, chan});
		@(negedge clk_250mhz);
		check_value(data_t'({relay_a, relay_b}), '0, "coils before pulse");
		len = 0;
		guard = 0;
		do begin
			@(posedge clk_250mhz);
			// Second command lands mid-pulse and must be dropped
			reg_wr    <= (len == 8);
			reg_addr  <= trigger_crossbar_pkg::REG_RELAY_CMD;
			reg_wdata <= {13'b0, !dir, chan + 2'd1};
			@(negedge clk_250mhz);
			coil  = dir ? relay_a : relay_b;
			other = dir ? relay_b : relay_a;
			check_value(data_t'(other), '0, "opposite bridge side");
			if (coil != '0) begin
				check_value(data_t'(coil), data_t'(4'b0001 << chan), "active coil");
				len++;
			end
			guard++;
		end while (coil != '0 && guard < PULSE_LIMIT);
		if (guard >= PULSE_LIMIT) begin
			$display("Relay %0d coil stayed on past %0d cycles, pulse never ended", chan, guard);
			error_count++;
		end
		check_value(data_t'(len), data_t'(trigger_crossbar_pkg::RELAY_PULSE_CYCLES),
			"coil pulse length");
		// No pulse from the dropped command
		repeat (8) begin
			@(posedge clk_250mhz);
			reg_wr <= 1'b0;
			@(negedge clk_250mhz);
			check_value(data_t'({relay_a, relay_b}), '0, "coils after pulse");
		end
		read_reg(trigger_crossbar_pkg::REG_RELAY_STAT, rd);
		check_value(rd, 16'h0002, "relay status with done");
		read_reg(trigger_crossbar_pkg::REG_RELAY_STAT, rd);
		check_value(rd, 16'h0000, "relay status after clear");
	endtask

	//////////////////////////////////////////////////
	// Main sequence and watchdog

	initial begin
		data_t rd;
		error_count = 0;
		check_count = 0;
		lfsr_state  = 32'ha77ebe5f;
		trig_in     = MASK;
		reg_wr      = 1'b0;
		reg_rd      = 1'b0;
		reg_addr    = '0;
		reg_wdata   = '0;
		fill_table();
		wait (rst_n === 1'b1);
		@(negedge clk_250mhz);
		check_value(data_t'(trig_out), '0, "trig_out after reset");
		check_value(data_t'({relay_a, relay_b}), '0, "coils after reset");
		check_value(reg_rdata, '0, "read data after reset");
		read_reg(trigger_crossbar_pkg::REG_MUXSEL_BASE, rd);
		check_value(rd, data_t'(trigger_crossbar_pkg::MUXSEL_OFF), "select 0 after reset");
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
		end
		led_test();
		relay_test(2'd1, 1'b1);
		relay_test(2'd3, 1'b0);
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the test hung before finishing", WATCHDOG_NS);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== trigger_crossbar.f ====
trigger_crossbar_pkg.sv
relay_if.sv
crossbar_matrix.sv
activity_stretch.sv
relay_controller.sv
mgmt_regs.sv
trigger_crossbar_top.sv
tb_clock_gen.sv
tb_trigger_crossbar.sv

// ==== trigger_crossbar_pkg.sv ====
package trigger_crossbar_pkg;

	//////////////////////////////////////////////////
	// Trigger crossbar geometry

	// Trigger inputs and outputs
	localparam int NUM_TRIG = 12;

	// Inputs whose P/N pair is swapped on the board
	localparam logic [NUM_TRIG-1:0] TRIG_SWAP_MASK = 12'h065;

	// Per-output select, 0..11 picks an input, anything above forces low
	typedef logic [3:0] muxsel_t;

	// Reset value of every select
	localparam muxsel_t MUXSEL_OFF = 4'd15;

	//////////////////////////////////////////////////
	// Relays and LED timing

	localparam int NUM_RELAY = 4;
	typedef logic [1:0] relay_chan_t;

	// Coil pulse length in clocks (short for simulation)
	localparam int RELAY_PULSE_CYCLES = 64;
	localparam int RELAY_CNT_W = $clog2(RELAY_PULSE_CYCLES);
	typedef logic [RELAY_CNT_W-1:0] relay_cnt_t;

	// LED stretch after the last active sample
	localparam int LED_HOLD_CYCLES = 32;
	localparam int LED_CNT_W = $clog2(LED_HOLD_CYCLES + 1);
	typedef logic [LED_CNT_W-1:0] led_cnt_t;

	//////////////////////////////////////////////////
	// Register map

	localparam int REG_ADDR_W = 6;
	localparam int REG_DATA_W = 16;

	// Selects for outputs 0..11 live at base + output index
	localparam logic [REG_ADDR_W-1:0] REG_MUXSEL_BASE = 6'd0;
	// Relay command, bits 1:0 channel, bit 2 direction
	localparam logic [REG_ADDR_W-1:0] REG_RELAY_CMD   = 6'd16;
	localparam int RELAY_CMD_DIR_BIT = 2;
	// LED readback
	localparam logic [REG_ADDR_W-1:0] REG_IN_LED      = 6'd32;
	localparam logic [REG_ADDR_W-1:0] REG_OUT_LED     = 6'd33;
	// Relay status, busy level and sticky done (clear on read)
	localparam logic [REG_ADDR_W-1:0] REG_RELAY_STAT  = 6'd34;
	localparam int RELAY_STAT_BUSY_BIT = 0;
	localparam int RELAY_STAT_DONE_BIT = 1;

endpackage

// ==== trigger_crossbar_top.sv ====
module trigger_crossbar_top (
	input  logic                                        clk_250mhz,
	input  logic                                        rst_n,
	input  logic [trigger_crossbar_pkg::NUM_TRIG-1:0]   trig_in,
	output logic [trigger_crossbar_pkg::NUM_TRIG-1:0]   trig_out,
	output logic [trigger_crossbar_pkg::NUM_RELAY-1:0]  relay_a,
	output logic [trigger_crossbar_pkg::NUM_RELAY-1:0]  relay_b,
	input  logic                                        reg_wr,
	input  logic                                        reg_rd,
	input  logic [trigger_crossbar_pkg::REG_ADDR_W-1:0] reg_addr,
	input  logic [trigger_crossbar_pkg::REG_DATA_W-1:0] reg_wdata,
	output logic [trigger_crossbar_pkg::REG_DATA_W-1:0] reg_rdata
);

	//////////////////////////////////////////////////
	// Crossbar and activity LEDs

	trigger_crossbar_pkg::muxsel_t [trigger_crossbar_pkg::NUM_TRIG-1:0] muxsel;
	logic [trigger_crossbar_pkg::NUM_TRIG-1:0] trig_fixed;
	logic [trigger_crossbar_pkg::NUM_TRIG-1:0] in_led;
	logic [trigger_crossbar_pkg::NUM_TRIG-1:0] out_led;

	crossbar_matrix matrix (
		.clk_250mhz (clk_250mhz),
		.rst_n      (rst_n),
		.trig_in    (trig_in),
		.muxsel     (muxsel),
		.trig_fixed (trig_fixed),
		.trig_out   (trig_out)
	);

	// Input LEDs follow the polarity-corrected inputs
	activity_stretch in_stretch (
		.clk_250mhz (clk_250mhz),
		.rst_n      (rst_n),
		.trig       (trig_fixed),
		.led        (in_led)
	);

	activity_stretch out_stretch (
		.clk_250mhz (clk_250mhz),
		.rst_n      (rst_n),
		.trig       (trig_out),
		.led        (out_led)
	);

	//////////////////////////////////////////////////
	// Relays and register port

	relay_if relay_bus ();

	relay_controller relays (
		.clk_250mhz (clk_250mhz),
		.rst_n      (rst_n),
		.relay      (relay_bus.relay),
		.relay_a    (relay_a),
		.relay_b    (relay_b)
	);

	mgmt_regs mgmt (
		.clk_250mhz (clk_250mhz),
		.rst_n      (rst_n),
		.reg_wr     (reg_wr),
		.reg_rd     (reg_rd),
		.reg_addr   (reg_addr),
		.reg_wdata  (reg_wdata),
		.reg_rdata  (reg_rdata),
		.muxsel     (muxsel),
		.in_led     (in_led),
		.out_led    (out_led),
		.relay      (relay_bus.mgmt)
	);

endmodule
